//--- hw/hires_pkg.sv
package hires_pkg;

    // the four hires display modes, selected by two register bits
    typedef enum logic [1:0] {
        mode_text      = 2'b00,
        mode_bitmap    = 2'b01,
        mode_planes    = 2'b10,
        mode_planes_bg = 2'b11
    } hires_mode_t;

    // attribute byte as seen in text mode
    typedef struct packed {
        logic       altc;
        logic       reverse;
        logic [1:0] rsvd;
        logic [3:0] fg;
    } hires_text_attr_t;

    // the same byte as seen in bitmap mode, one color per nibble
    typedef struct packed {
        logic [3:0] fg;
        logic [3:0] bg;
    } hires_bitmap_attr_t;

    // in the plane modes the color byte holds plane 2 pixels and is read through raw
    typedef union packed {
        hires_text_attr_t   text;
        hires_bitmap_attr_t bitmap;
        logic [7:0]         raw;
    } hires_attr_u;

    // fetching starts in the high half of the first cycle and ends in the low half of the last
    localparam logic [6:0] fetch_first_cycle = 7'd14;
    localparam logic [6:0] fetch_last_cycle  = 7'd54;

    // phase strobes used inside each fetch half cycle
    localparam int phase_color_addr = 2;
    localparam int phase_char_addr  = 4;
    localparam int phase_pixel_addr = 6;
    localparam int phase_pixel_data = 8;
    localparam int phase_load       = 10;

    // vc moves on by one full row of characters when rc wraps
    localparam logic [10:0] chars_per_row = 11'd80;

    // true for every half cycle of phi that carries a fetch, 80 per line
    function automatic logic in_fetch_window(input logic [6:0] cycle_num, input logic clk_phi);
        return (cycle_num == fetch_first_cycle && clk_phi) ||
               (cycle_num > fetch_first_cycle && cycle_num < fetch_last_cycle) ||
               (cycle_num == fetch_last_cycle && !clk_phi);
    endfunction

endpackage

//--- hw/hires_timing_if.sv
`timescale 1ns/1ns

// timing bundle shared by the controller and the two datapath blocks
interface hires_timing_if;

    logic        clk_phi;
    // one-hot phase within the current phi half cycle
    logic [15:0] phi_phase_start;
    logic [6:0]  cycle_num;
    logic [8:0]  raster_line;
    logic [2:0]  rc;
    logic [10:0] vc;
    logic [13:0] fvc;

    // the controller owns every signal
    modport ctrl (
        output clk_phi, phi_phase_start, cycle_num, raster_line, rc, vc, fvc
    );

    // address generator and pixel sequencer only look
    modport fetch (
        input clk_phi, phi_phase_start, cycle_num, raster_line, rc, vc, fvc
    );

endinterface

//--- hw/hires_timing_ctrl.sv
`timescale 1ns/1ns

module hires_timing_ctrl import hires_pkg::*; #(
    parameter int cycles_per_line = 63,
    parameter int lines_per_frame = 312
) (
    input logic          clk_dot4x,
    input logic          rst_n,
    hires_timing_if.ctrl tif
);

    // start of the current character row, vc reloads from here every line
    logic [10:0] vc_base;
    logic        phase_last;
    logic        fetch_half;
    logic        line_end;
    logic        frame_end;

    // everything below moves on the last phase of a half cycle
    assign phase_last = tif.phi_phase_start[15];

    assign fetch_half = in_fetch_window(tif.cycle_num, tif.clk_phi);

    // the line ends with the high half of its last cycle
    assign line_end = phase_last && tif.clk_phi &&
                      (tif.cycle_num == 7'(cycles_per_line - 1));

    assign frame_end = line_end && (tif.raster_line == 9'(lines_per_frame - 1));

    // phase ring, one bit per dot4x clock, 16 clocks per half of phi
    always_ff @(posedge clk_dot4x) begin
        if (!rst_n) begin
            tif.phi_phase_start <= 16'h0001;
            tif.clk_phi         <= 1'b0;
        end else begin
            tif.phi_phase_start <= {tif.phi_phase_start[14:0], tif.phi_phase_start[15]};
            // phi flips exactly as phase 0 comes round again
            if (phase_last) begin
                tif.clk_phi <= ~tif.clk_phi;
            end
        end
    end

    // a cycle is a low half followed by a high half, so the count moves as phi falls
    always_ff @(posedge clk_dot4x) begin
        if (!rst_n) begin
            tif.cycle_num   <= 7'd0;
            tif.raster_line <= 9'd0;
        end else if (phase_last && tif.clk_phi) begin
            if (line_end) begin
                tif.cycle_num <= 7'd0;
                if (frame_end) begin
                    tif.raster_line <= 9'd0;
                end else begin
                    tif.raster_line <= tif.raster_line + 9'd1;
                end
            end else begin
                tif.cycle_num <= tif.cycle_num + 7'd1;
            end
        end
    end

    // character row and matrix counters
    always_ff @(posedge clk_dot4x) begin
        if (!rst_n) begin
            tif.rc  <= 3'd0;
            tif.vc  <= 11'd0;
            tif.fvc <= 14'd0;
            vc_base <= 11'd0;
        end else if (phase_last) begin
            // both counters step once per fetch, after the half cycle has used them
            if (fetch_half) begin
                tif.vc  <= tif.vc + 11'd1;
                tif.fvc <= tif.fvc + 14'd1;
            end
            if (frame_end) begin
                // the display has no vertical border, so a new frame starts at row 0
                tif.rc  <= 3'd0;
                tif.vc  <= 11'd0;
                tif.fvc <= 14'd0;
                vc_base <= 11'd0;
            end else if (line_end) begin
                tif.rc <= tif.rc + 3'd1;
                if (tif.rc == 3'd7) begin
                    // eighth line done, move the row base to the next row of characters
                    vc_base <= vc_base + chars_per_row;
                    tif.vc  <= vc_base + chars_per_row;
                end else begin
                    // same row again, fetch the same characters with the next glyph line
                    tif.vc <= vc_base;
                end
            end
        end
    end

endmodule

//--- hw/hires_addressgen.sv
`timescale 1ns/1ns

// three reads per fetch half: attribute, character pointer, then pixels
module hires_addressgen import hires_pkg::*; (
    input  logic          clk_dot4x,
    hires_timing_if.fetch tif,
    input  hires_mode_t   hires_mode,
    input  logic [2:0]    char_pixel_base,
    input  logic [3:0]    matrix_base,
    input  logic [3:0]    color_base,
    input  logic          char_case,
    output logic [14:0]   video_mem_addr,
    input  logic [7:0]    video_mem_data,
    output logic [7:0]    hires_pixel_data,
    output hires_attr_u   hires_color_data
);

    logic fetch_half;
    // selects the upper half of the character set
    logic char_half;

    assign fetch_half = in_fetch_window(tif.cycle_num, tif.clk_phi);

    // the attribute byte was captured two phases before it is needed here
    assign char_half = char_case | hires_color_data.text.altc;

    // a byte addressed on one strobe is on video_mem_data by the strobe two phases later
    always_ff @(posedge clk_dot4x) begin
        if (fetch_half) begin
            if (tif.phi_phase_start[phase_color_addr]) begin
                case (hires_mode)
                    mode_text, mode_bitmap: begin
                        // one attribute per character cell
                        video_mem_addr <= {color_base, tif.vc};
                    end
                    default: begin
                        // plane 2 sits in the upper 16K
                        video_mem_addr <= {1'b1, tif.fvc};
                    end
                endcase
            end else if (tif.phi_phase_start[phase_char_addr]) begin
                hires_color_data.raw <= video_mem_data;
                // only text mode needs a character pointer, the slot stays idle otherwise
                if (hires_mode == mode_text) begin
                    video_mem_addr <= {matrix_base, tif.vc};
                end
            end else if (tif.phi_phase_start[phase_pixel_addr]) begin
                case (hires_mode)
                    mode_text: begin
                        // glyph line rc of the character just read, taken straight off the bus
                        video_mem_addr <= {char_pixel_base, char_half, video_mem_data, tif.rc};
                    end
                    mode_bitmap: begin
                        video_mem_addr <= {matrix_base[0], tif.fvc};
                    end
                    default: begin
                        // plane 1 in the lower 16K
                        video_mem_addr <= {1'b0, tif.fvc};
                    end
                endcase
            end else if (tif.phi_phase_start[phase_pixel_data]) begin
                // held for the sequencer load on phase 10
                hires_pixel_data <= video_mem_data;
            end
        end
    end

endmodule

//--- hw/hires_video_ram.sv
`timescale 1ns/1ns

// dedicated 32K x 8 video memory, the display reads and the host only writes
module hires_video_ram (
    input  logic        clk_dot4x,
    input  logic [14:0] video_mem_addr,
    output logic [7:0]  video_mem_data,
    input  logic        host_we,
    input  logic [14:0] host_addr,
    input  logic [7:0]  host_data
);

    logic [7:0] mem [0:32767];

    // host port, a single strobe writes one byte
    always_ff @(posedge clk_dot4x) begin
        if (host_we) begin
            mem[host_addr] <= host_data;
        end
    end

    // registered read port
    // the fetch address is itself registered in the address generator, so a byte
    // lands here two clocks after its address strobe
    always_ff @(posedge clk_dot4x) begin
        video_mem_data <= mem[video_mem_addr];
    end

endmodule

//--- hw/hires_pixel_sequencer.sv
`timescale 1ns/1ns

// turns each fetched byte pair into eight pixels, two dot4x clocks per pixel
module hires_pixel_sequencer import hires_pkg::*; (
    input  logic          clk_dot4x,
    input  logic          rst_n,
    hires_timing_if.fetch tif,
    input  hires_mode_t   hires_mode,
    input  logic [3:0]    bg_color,
    input  logic [7:0]    hires_pixel_data,
    input  hires_attr_u   hires_color_data,
    output logic [3:0]    pixel_color,
    output logic          pixel_strobe
);

    // glyph, bitmap or plane 1 bits, msb goes out first
    logic [7:0]  pix_sr;
    // attribute byte, doubles as the plane 2 shifter in the plane modes
    hires_attr_u attr_q;
    logic [3:0]  pix_left;
    // strobe divider, a pixel goes out when it is low
    logic        div;
    logic        load;
    logic        emit;
    logic [1:0]  plane_idx;
    logic [3:0]  next_color;

    // only halves that held a fetch get loaded, so no strobes outside the window
    assign load = in_fetch_window(tif.cycle_num, tif.clk_phi) &&
                  tif.phi_phase_start[phase_load];

    assign emit = (pix_left != 4'd0) && !div;

    // plane 2 bit is the high bit of the four color index
    assign plane_idx = {attr_q.raw[7], pix_sr[7]};

    always_comb begin
        case (hires_mode)
            mode_text: begin
                // reverse swaps which pixel value shows the foreground
                next_color = (pix_sr[7] ^ attr_q.text.reverse) ? attr_q.text.fg : bg_color;
            end
            mode_bitmap: begin
                next_color = pix_sr[7] ? attr_q.bitmap.fg : attr_q.bitmap.bg;
            end
            mode_planes: begin
                next_color = {2'b00, plane_idx};
            end
            default: begin
                // index 0 is replaced by the background register
                next_color = (plane_idx == 2'd0) ? bg_color : {2'b00, plane_idx};
            end
        endcase
    end

    // shift pair
    always_ff @(posedge clk_dot4x) begin
        if (load) begin
            pix_sr <= hires_pixel_data;
            attr_q <= hires_color_data;
        end else if (emit) begin
            pix_sr <= {pix_sr[6:0], 1'b0};
            // text and bitmap keep their attribute for the whole cell
            if (hires_mode == mode_planes || hires_mode == mode_planes_bg) begin
                attr_q.raw <= {attr_q.raw[6:0], 1'b0};
            end
        end
    end

    // eight emits at two clocks each fill the 16 clocks up to the next phase 10 load
    always_ff @(posedge clk_dot4x) begin
        if (!rst_n) begin
            pix_left     <= 4'd0;
            div          <= 1'b0;
            pixel_strobe <= 1'b0;
            pixel_color  <= 4'd0;
        end else begin
            pixel_strobe <= emit;
            if (emit) begin
                pixel_color <= next_color;
            end
            if (load) begin
                pix_left <= 4'd8;
                div      <= 1'b0;
            end else if (pix_left != 4'd0) begin
                div <= ~div;
                if (emit) begin
                    pix_left <= pix_left - 4'd1;
                end
            end
        end
    end

endmodule

//--- hw/hires_video_top.sv
`timescale 1ns/1ns

// 80 column hires video path, timing, fetch, video memory and pixel output
module hires_video_top import hires_pkg::*; #(
    parameter int cycles_per_line = 63,
    parameter int lines_per_frame = 312
) (
    input  logic        clk_dot4x,
    input  logic        rst_n,
    input  logic        host_we,
    input  logic [14:0] host_addr,
    input  logic [7:0]  host_data,
    input  hires_mode_t hires_mode,
    input  logic [2:0]  char_pixel_base,
    input  logic [3:0]  matrix_base,
    input  logic [3:0]  color_base,
    input  logic        char_case,
    input  logic [3:0]  bg_color,
    output logic [3:0]  pixel_color,
    output logic        pixel_strobe,
    output logic [8:0]  raster_line
);

    logic [14:0] video_mem_addr;
    logic [7:0]  video_mem_data;
    logic [7:0]  hires_pixel_data;
    hires_attr_u hires_color_data;

    hires_timing_if tif ();

    // line and frame lengths live only in the controller
    hires_timing_ctrl #(
        .cycles_per_line (cycles_per_line),
        .lines_per_frame (lines_per_frame)
    ) u_timing_ctrl (
        .clk_dot4x (clk_dot4x),
        .rst_n     (rst_n),
        .tif       (tif.ctrl)
    );

    hires_addressgen u_addressgen (
        .clk_dot4x        (clk_dot4x),
        .tif              (tif.fetch),
        .hires_mode       (hires_mode),
        .char_pixel_base  (char_pixel_base),
        .matrix_base      (matrix_base),
        .color_base       (color_base),
        .char_case        (char_case),
        .video_mem_addr   (video_mem_addr),
        .video_mem_data   (video_mem_data),
        .hires_pixel_data (hires_pixel_data),
        .hires_color_data (hires_color_data)
    );

    // host writes go straight into the memory, there is no back-pressure
    hires_video_ram u_video_ram (
        .clk_dot4x      (clk_dot4x),
        .video_mem_addr (video_mem_addr),
        .video_mem_data (video_mem_data),
        .host_we        (host_we),
        .host_addr      (host_addr),
        .host_data      (host_data)
    );

    hires_pixel_sequencer u_pixel_sequencer (
        .clk_dot4x        (clk_dot4x),
        .rst_n            (rst_n),
        .tif              (tif.fetch),
        .hires_mode       (hires_mode),
        .bg_color         (bg_color),
        .hires_pixel_data (hires_pixel_data),
        .hires_color_data (hires_color_data),
        .pixel_color      (pixel_color),
        .pixel_strobe     (pixel_strobe)
    );

    // the line number goes out so pixels can be matched to their raster line
    assign raster_line = tif.raster_line;

endmodule

//--- verification/hires_clock_gen.sv
`timescale 1ns/1ns

// free running 4 ns dot clock with a synchronous active low reset
module hires_clock_gen #(
    parameter int reset_cycles = 4
) (
    input  logic reset_req,
    output logic clk_dot4x,
    output logic rst_n
);

    int hold_count = reset_cycles;
    bit req;

    initial begin
        clk_dot4x = 1'b0;
        rst_n     = 1'b0;
        forever begin
            #2 clk_dot4x = ~clk_dot4x;
        end
    end

    // the request is taken on the edge and rst_n moves 1 ns later, like every other input
    always @(posedge clk_dot4x) begin
        req = reset_req;
        #1;
        if (req) begin
            hold_count = reset_cycles;
            rst_n      = 1'b0;
        end else if (hold_count > 0) begin
            // reset stays low for four more cycles after the request is dropped
            hold_count = hold_count - 1;
            rst_n      = 1'b0;
        end else begin
            rst_n = 1'b1;
        end
    end

endmodule

//--- verification/hires_video_tb.sv
`timescale 1ns/1ns

// fills the video memory with random bytes and checks one raster line per table entry
module hires_video_tb import hires_pkg::*; ();

    localparam int num_tests      = 7;
    localparam int line_pixels    = 640;
    localparam int line_timeout   = 30000;
    localparam int strobe_timeout = 1000;

    logic        clk_dot4x;
    logic        rst_n;
    logic        reset_req = 1'b1;
    logic        host_we = 1'b0;
    logic [14:0] host_addr = 15'd0;
    logic [7:0]  host_data = 8'd0;
    hires_mode_t hires_mode = mode_text;
    logic [2:0]  char_pixel_base = 3'd0;
    logic [3:0]  matrix_base = 4'd0;
    logic [3:0]  color_base = 4'd0;
    logic        char_case = 1'b0;
    logic [3:0]  bg_color = 4'd0;
    logic [3:0]  pixel_color;
    logic        pixel_strobe;
    logic [8:0]  raster_line;

    // stimulus table, one column per register input and the line that gets checked
    string       test_name [num_tests];
    hires_mode_t test_mode [num_tests];
    logic [2:0]  test_char_base [num_tests];
    logic [3:0]  test_matrix_base [num_tests];
    logic [3:0]  test_color_base [num_tests];
    logic        test_char_case [num_tests];
    logic [3:0]  test_bg [num_tests];
    int          test_line [num_tests];

    // copy of the video memory and the pixels the model expects on the line
    logic [7:0]  ref_mem [0:32767];
    logic [3:0]  exp_pix [0:line_pixels-1];
    int          seed = 18;
    int          test_errors;
    int          pass_count = 0;
    int          fail_count = 0;
    // set while no pixel has been strobed since the last reset
    bit          fresh;

    hires_clock_gen u_clock_gen (
        .reset_req (reset_req),
        .clk_dot4x (clk_dot4x),
        .rst_n     (rst_n)
    );

    hires_video_top #(
        .cycles_per_line (63),
        .lines_per_frame (312)
    ) u_hires_video_top (
        .clk_dot4x       (clk_dot4x),
        .rst_n           (rst_n),
        .host_we         (host_we),
        .host_addr       (host_addr),
        .host_data       (host_data),
        .hires_mode      (hires_mode),
        .char_pixel_base (char_pixel_base),
        .matrix_base     (matrix_base),
        .color_base      (color_base),
        .char_case       (char_case),
        .bg_color        (bg_color),
        .pixel_color     (pixel_color),
        .pixel_strobe    (pixel_strobe),
        .raster_line     (raster_line)
    );

    task automatic set_entry(input int i, input string name, input hires_mode_t mode,
                             input logic [2:0] cpb, input logic [3:0] mb, input logic [3:0] cb,
                             input logic cc, input logic [3:0] bg, input int line);
        test_name[i]        = name;
        test_mode[i]        = mode;
        test_char_base[i]   = cpb;
        test_matrix_base[i] = mb;
        test_color_base[i]  = cb;
        test_char_case[i]   = cc;
        test_bg[i]          = bg;
        test_line[i]        = line;
    endtask

    // one host write per clock over the whole 32K, the model keeps the same bytes
    task automatic load_video_ram();
        int a;
        logic [31:0] rnd;
        for (a = 0; a < 32768; a++) begin
            @(posedge clk_dot4x);
            #1;
            rnd       = $random(seed);
            host_we   = 1'b1;
            host_addr = 15'(a);
            host_data = rnd[7:0];
            ref_mem[a] = rnd[7:0];
        end
        @(posedge clk_dot4x);
        #1;
        host_we = 1'b0;
    endtask

    // 80 fetches per line, vc counts from the row base and fvc from 80 times the line
    task automatic build_expected(input int t);
        int k;
        int b;
        logic [10:0] vc;
        logic [13:0] fvc;
        logic [2:0]  rc;
        logic [7:0]  attr;
        logic [7:0]  ptr;
        logic [7:0]  pix;
        logic        half;
        logic [1:0]  idx;
        logic [3:0]  col;
        rc = 3'(test_line[t] % 8);
        for (k = 0; k < 80; k++) begin
            vc   = 11'(80 * (test_line[t] / 8) + k);
            fvc  = 14'(80 * test_line[t] + k);
            attr = ref_mem[{test_color_base[t], vc}];
            case (test_mode[t])
                mode_text: begin
                    // altc or char_case picks the upper half of the character set
                    ptr  = ref_mem[{test_matrix_base[t], vc}];
                    half = test_char_case[t] | attr[7];
                    pix  = ref_mem[{test_char_base[t], half, ptr, rc}];
                end
                mode_bitmap: begin
                    pix = ref_mem[{test_matrix_base[t][0], fvc}];
                end
                default: begin
                    // the attribute slot carries plane 2 from the upper 16K
                    attr = ref_mem[{1'b1, fvc}];
                    pix  = ref_mem[{1'b0, fvc}];
                end
            endcase
            for (b = 7; b >= 0; b--) begin
                idx = {attr[b], pix[b]};
                case (test_mode[t])
                    mode_text:   col = (pix[b] ^ attr[6]) ? attr[3:0] : test_bg[t];
                    mode_bitmap: col = pix[b] ? attr[7:4] : attr[3:0];
                    mode_planes: col = {2'b00, idx};
                    default:     col = (idx == 2'd0) ? test_bg[t] : {2'b00, idx};
                endcase
                exp_pix[k * 8 + 7 - b] = col;
            end
        end
    endtask

    // pixel_color has to stay 0 from reset until the first strobe
    task automatic note_sample();
        if (pixel_strobe) begin
            fresh = 1'b0;
        end else if (fresh) begin
            assert (pixel_color == 4'd0) else begin
                $display("** Error at %0t ns: pixel_color %0h before the first fetch",
                         $time, pixel_color);
                test_errors++;
            end
        end
    endtask

    // polls raster_line on falling edges until it does, or does not, equal line
    task automatic wait_line(input int line, input bit want_equal, output bit ok);
        int waited;
        waited = 0;
        ok     = 1'b0;
        while (!ok && waited < line_timeout) begin
            @(negedge clk_dot4x);
            note_sample();
            ok = ((raster_line == 9'(line)) == want_equal);
            // after the 640th pixel nothing strobes until the line is over
            if (!want_equal && !ok) begin
                assert (!pixel_strobe) else begin
                    $display("** Error at %0t ns: pixel strobe after the end of line %0d",
                             $time, line);
                    test_errors++;
                end
            end
            waited++;
        end
        assert (ok) else begin
            $display("timeout: raster_line did not %s line %0d in time",
                     want_equal ? "reach" : "leave", line);
            test_errors++;
        end
    endtask

    task automatic wait_strobe(output bit ok);
        int waited;
        waited = 0;
        @(negedge clk_dot4x);
        note_sample();
        while (!pixel_strobe && waited < strobe_timeout) begin
            @(negedge clk_dot4x);
            note_sample();
            waited++;
        end
        ok = pixel_strobe;
        assert (ok) else begin
            $display("timeout: no pixel strobe came within %0d clocks", strobe_timeout);
            test_errors++;
        end
    endtask

    task automatic run_test(input int t);
        int i;
        bit ok;
        test_errors = 0;
        @(posedge clk_dot4x);
        #1;
        reset_req = 1'b1;
        fresh     = 1'b1;
        load_video_ram();
        build_expected(t);
        hires_mode      = test_mode[t];
        char_pixel_base = test_char_base[t];
        matrix_base     = test_matrix_base[t];
        color_base      = test_color_base[t];
        char_case       = test_char_case[t];
        bg_color        = test_bg[t];
        reset_req       = 1'b0;
        wait_line(test_line[t], 1'b1, ok);
        for (i = 0; i < line_pixels && ok; i++) begin
            wait_strobe(ok);
            if (ok) begin
                assert (pixel_color == exp_pix[i]) else begin
                    $display("** Error at %0t ns: %s pixel %0d expected %0h got %0h",
                             $time, test_name[t], i, exp_pix[i], pixel_color);
                    test_errors++;
                end
            end
        end
        if (ok) begin
            wait_line(test_line[t], 1'b0, ok);
        end
        if (test_errors == 0) begin
            pass_count++;
            $display("test %s on line %0d passed", test_name[t], test_line[t]);
        end else begin
            fail_count++;
            $display("test %s on line %0d failed with %0d errors", test_name[t], test_line[t],
                     test_errors);
        end
    endtask

    initial begin
        int t;
        set_entry(0, "text_line0", mode_text, 3'd2, 4'h1, 4'h3, 1'b0, 4'h6, 0);
        set_entry(1, "text_rc3", mode_text, 3'd5, 4'h4, 4'h6, 1'b0, 4'h9, 3);
        // char_case forces the upper glyph half whatever altc says
        set_entry(2, "text_char_case", mode_text, 3'd2, 4'h1, 4'h3, 1'b1, 4'h6, 2);
        set_entry(3, "bitmap_line5", mode_bitmap, 3'd0, 4'h7, 4'h2, 1'b0, 4'h0, 5);
        set_entry(4, "planes_line1", mode_planes, 3'd0, 4'h0, 4'h0, 1'b0, 4'h5, 1);
        set_entry(5, "planes_bg_line4", mode_planes_bg, 3'd0, 4'h0, 4'h0, 1'b0, 4'hc, 4);
        // line 9 is rc 1 of the second character row
        set_entry(6, "text_row1_line9", mode_text, 3'd6, 4'h9, 4'ha, 1'b0, 4'h3, 9);
        for (t = 0; t < num_tests; t++) begin
            run_test(t);
        end
        $display("tests passed: %0d, tests failed: %0d", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

//--- compile.f
hw/hires_pkg.sv
hw/hires_timing_if.sv
hw/hires_timing_ctrl.sv
hw/hires_addressgen.sv
hw/hires_video_ram.sv
hw/hires_pixel_sequencer.sv
hw/hires_video_top.sv
verification/hires_clock_gen.sv
verification/hires_video_tb.sv
